//--- Makefile
# Verilator flow for the Wishbone I/O block

VERILATOR ?= verilator
TOP       ?= tb_io_board
LOG       ?= sim.log
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

  // Wishbone port widths
  localparam int WB_ADDR_W = 6;   // Word address
  localparam int WB_DATA_W = 16;

  // Address layout: register select above modify operation
  localparam int REG_SEL_W   = 4;
  localparam int MOD_OP_W    = 2;
  localparam int ADR_OP_LSB  = 0;                        // Bits 1..0
  localparam int ADR_SEL_LSB = ADR_OP_LSB + MOD_OP_W;    // Bits 5..2

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [WB_DATA_W-1:0] wb_data_t;
  typedef logic [REG_SEL_W-1:0] reg_sel_t;
  typedef logic [MOD_OP_W-1:0]  mod_op_t;

  // Register selects, codes 7..15 unused
  localparam reg_sel_t SEL_PIN_IN    = 4'd0;
  localparam reg_sel_t SEL_PIN_OUT   = 4'd1;
  localparam reg_sel_t SEL_PIN_DIR   = 4'd2;
  localparam reg_sel_t SEL_LEDS      = 4'd3;
  localparam reg_sel_t SEL_SDM_RED   = 4'd4;  // Dimmer channels consecutive
  localparam reg_sel_t SEL_SDM_GREEN = 4'd5;
  localparam reg_sel_t SEL_SDM_BLUE  = 4'd6;

  // Modify operations
  localparam mod_op_t OP_WRITE  = 2'd0;
  localparam mod_op_t OP_CLEAR  = 2'd1;  // Clear bits set in data
  localparam mod_op_t OP_SET    = 2'd2;
  localparam mod_op_t OP_TOGGLE = 2'd3;

  // Master side of the classic bus
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  // Slave side
  typedef struct packed {
    logic     ack;
    wb_data_t dat;  // Zero outside read ack
  } wb_rsp_t;

  // One-cycle write command to the register groups
  typedef struct packed {
    logic     en;
    reg_sel_t sel;
    mod_op_t  op;
    wb_data_t data;
  } reg_wr_t;

endpackage

`default_nettype wire

//--- gpio_bank.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_bank (
  input  logic             clk,
  input  logic             reset_button,
  input  bus_pkg::reg_wr_t reg_wr,
  input  io_pkg::pin_t     pin_in,
  output io_pkg::pin_t     pin_out,
  output io_pkg::pin_t     pin_oe,
  output io_pkg::led_t     leds,
  output io_pkg::gpio_rd_t gpio_rd
);

  import bus_pkg::*;
  import io_pkg::*;

  pin_t                   out_q;
  pin_t                   dir_q;   // 1 drives the pin
  led_t                   leds_q;
  pin_t [SYNC_STAGES-1:0] sync_q;  // Stage 0 samples the raw pins
  logic                   wr_out;
  logic                   wr_dir;
  logic                   wr_leds;

  // Write, clear, set or toggle on a bus-wide word
  function automatic wb_data_t modify(input wb_data_t cur, input wb_data_t din,
                                      input mod_op_t op);
    wb_data_t res;
    case (op)
      OP_WRITE:  res = din;
      OP_CLEAR:  res = cur & ~din;
      OP_SET:    res = cur | din;
      OP_TOGGLE: res = cur ^ din;
      default:   res = cur;
    endcase
    return res;
  endfunction

  assign wr_out  = reg_wr.en && (reg_wr.sel == SEL_PIN_OUT);
  assign wr_dir  = reg_wr.en && (reg_wr.sel == SEL_PIN_DIR);
  assign wr_leds = reg_wr.en && (reg_wr.sel == SEL_LEDS);

  always_ff @(posedge clk) begin
    if (reset_button) begin
      out_q  <= PIN_OUT_RST;
      dir_q  <= PIN_DIR_RST;
      leds_q <= LEDS_RST;
    end else begin
      // Upper data bits drop off in the casts
      if (wr_out)
        out_q <= pin_t'(modify(wb_data_t'(out_q), reg_wr.data, reg_wr.op));
      if (wr_dir)
        dir_q <= pin_t'(modify(wb_data_t'(dir_q), reg_wr.data, reg_wr.op));
      if (wr_leds)
        leds_q <= led_t'(modify(wb_data_t'(leds_q), reg_wr.data, reg_wr.op));
    end
  end

  // Two-flop synchronizer for the async pins
  always_ff @(posedge clk) begin
    sync_q <= {sync_q[SYNC_STAGES-2:0], pin_in};
  end

  assign pin_out = out_q;
  assign pin_oe  = dir_q;
  assign leds    = leds_q;

  assign gpio_rd.pin_in  = sync_q[SYNC_STAGES-1];
  assign gpio_rd.pin_out = out_q;
  assign gpio_rd.pin_dir = dir_q;
  assign gpio_rd.leds    = leds_q;

  // Pins come out of reset undriven
  a_oe_after_reset: assert property (@(posedge clk)
    reset_button |=> (pin_oe == '0))
    else $error("pin_oe not zero after reset");

endmodule

`default_nettype wire

//--- io_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_board_top (
  input  logic             clk,
  input  logic             reset_button,
  input  bus_pkg::wb_req_t wb_req,
  output bus_pkg::wb_rsp_t wb_rsp,
  input  io_pkg::pin_t     pin_in,
  output io_pkg::pin_t     pin_out,
  output io_pkg::pin_t     pin_oe,
  output logic             led_red,
  output logic             led_green,
  output logic             led_blue
);

  import bus_pkg::*;
  import io_pkg::*;

  reg_wr_t  reg_wr;   // Write command to both groups
  gpio_rd_t gpio_rd;
  sdm_rd_t  sdm_rd;
  led_t     leds;     // LED register into the dimmer

  wb_reg_slave u_slave (
    .clk          (clk),
    .reset_button (reset_button),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .reg_wr       (reg_wr),
    .gpio_rd      (gpio_rd),
    .sdm_rd       (sdm_rd)
  );

  gpio_bank u_gpio (
    .clk          (clk),
    .reset_button (reset_button),
    .reg_wr       (reg_wr),
    .pin_in       (pin_in),
    .pin_out      (pin_out),
    .pin_oe       (pin_oe),
    .leds         (leds),
    .gpio_rd      (gpio_rd)
  );

  led_dimmer u_dimmer (
    .clk          (clk),
    .reset_button (reset_button),
    .reg_wr       (reg_wr),
    .leds         (leds),
    .led_red      (led_red),
    .led_green    (led_green),
    .led_blue     (led_blue),
    .sdm_rd       (sdm_rd)
  );

endmodule

`default_nettype wire

//--- io_pkg.sv
`default_nettype none

package io_pkg;

  localparam int PIN_W       = 8;
  localparam int LED_W       = 3;   // Red, green, blue from bit 0
  localparam int SDM_W       = 16;  // Dimmer level and phase width
  localparam int SYNC_STAGES = 2;   // Pin input synchronizer depth

  typedef logic [PIN_W-1:0] pin_t;
  typedef logic [LED_W-1:0] led_t;
  typedef logic [SDM_W-1:0] sdm_t;

  // Reset values
  localparam pin_t PIN_OUT_RST = '0;
  localparam pin_t PIN_DIR_RST = '0;  // Every pin an input
  localparam led_t LEDS_RST    = '0;
  localparam sdm_t SDM_RST     = '0;  // Levels and phases

  // Read-back from the pin and LED registers
  typedef struct packed {
    pin_t pin_in;   // Synchronized
    pin_t pin_out;
    pin_t pin_dir;
    led_t leds;
  } gpio_rd_t;

  // Read-back of the dimmer levels
  typedef struct packed {
    sdm_t red;
    sdm_t green;
    sdm_t blue;
  } sdm_rd_t;

endpackage

`default_nettype wire

//--- led_dimmer.sv
`timescale 1ns/1ps
`default_nettype none

module led_dimmer (
  input  logic             clk,
  input  logic             reset_button,
  input  bus_pkg::reg_wr_t reg_wr,
  input  io_pkg::led_t     leds,
  output logic             led_red,
  output logic             led_green,
  output logic             led_blue,
  output io_pkg::sdm_rd_t  sdm_rd
);

  import bus_pkg::*;
  import io_pkg::*;

  sdm_t level_q [LED_W];  // Index 0 red, 1 green, 2 blue
  sdm_t phase_q [LED_W];
  led_t pulse_q;          // Registered carry per colour
  led_t led_out;

  // Sigma-delta: phase accumulates level, carry out is the pulse
  always_ff @(posedge clk) begin
    if (reset_button) begin
      for (int i = 0; i < LED_W; i++) begin
        level_q[i] <= SDM_RST;
        phase_q[i] <= SDM_RST;
      end
      pulse_q <= '0;
    end else begin
      for (int i = 0; i < LED_W; i++) begin
        // Selects follow SEL_SDM_RED in colour order, op ignored
        if (reg_wr.en && (reg_wr.sel == reg_sel_t'(SEL_SDM_RED + i)))
          level_q[i] <= reg_wr.data;
        {pulse_q[i], phase_q[i]} <= {1'b0, phase_q[i]} + {1'b0, level_q[i]};
      end
    end
  end

  assign led_out   = leds | pulse_q;  // Register bit forces the LED on
  assign led_red   = led_out[0];
  assign led_green = led_out[1];
  assign led_blue  = led_out[2];

  assign sdm_rd.red   = level_q[0];
  assign sdm_rd.green = level_q[1];
  assign sdm_rd.blue  = level_q[2];

  // A dark channel never pulses
  for (genvar g = 0; g < LED_W; g++) begin : g_sdm_chk
    a_zero_level: assert property (@(posedge clk) disable iff (reset_button)
      (level_q[g] == '0) |=> !pulse_q[g])
      else $error("pulse on channel %0d with zero level", g);
  end

endmodule

`default_nettype wire

//--- list.f
bus_pkg.sv
io_pkg.sv
wb_reg_slave.sv
gpio_bank.sv
led_dimmer.sv
io_board_top.sv
tb_io_board.sv

//--- tb_io_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_io_board;

  import bus_pkg::*;
  import io_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_MODIFY   = 60;  // Random pin and LED register writes
  localparam int N_PINS     = 20;  // Held pin_in values
  localparam int N_DIM      = 8;   // Dimmer rounds
  localparam int DIM_RUN    = 64;  // Free-running cycles per round
  localparam int N_BUS      = 20;  // Unused-select and stray-strobe rounds
  // Cycle budget, one access is at most 4 cycles
  localparam int TEST_CYCLES = 3 + (50 + 16 * 4) + N_MODIFY * 8 + N_PINS * 8
                             + N_DIM * (7 * 4 + DIM_RUN) + N_BUS * 16 + 6 * 4;
  localparam int TIMEOUT_NS  = 2 * TEST_CYCLES * CLK_PERIOD;  // Twice the budget

  logic    clk;
  logic    reset_button;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  pin_t    pin_in;
  pin_t    pin_out;
  pin_t    pin_oe;
  logic    led_red;
  logic    led_green;
  logic    led_blue;

  // Reference model state
  pin_t    m_out;
  pin_t    m_dir;
  led_t    m_leds;
  sdm_t    m_level [3];  // Red, green, blue
  sdm_t    m_phase [3];
  led_t    m_pulse;
  logic    m_ack;        // Expected ack
  pin_t    m_pin;        // Value held on pin_in

  int      seed;
  int      n_checks;
  int      n_fails;
  logic    chk_on;       // Per-cycle checks after reset

  io_board_top uut (
    .clk          (clk),
    .reset_button (reset_button),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .pin_in       (pin_in),
    .pin_out      (pin_out),
    .pin_oe       (pin_oe),
    .led_red      (led_red),
    .led_green    (led_green),
    .led_blue     (led_blue)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic wb_data_t rand_word();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Write, clear, set, toggle
  function automatic wb_data_t bit_update(input wb_data_t cur, input wb_data_t din,
                                          input mod_op_t op);
    case (op)
      OP_WRITE: return din;
      OP_CLEAR: return cur & ~din;
      OP_SET:   return cur | din;
      default:  return cur ^ din;
    endcase
  endfunction

  // Expected read word per select
  function automatic wb_data_t model_read(input reg_sel_t sel);
    case (sel)
      SEL_PIN_IN:    return {8'h00, m_pin};
      SEL_PIN_OUT:   return {8'h00, m_out};
      SEL_PIN_DIR:   return {8'h00, m_dir};
      SEL_LEDS:      return {13'h0000, m_leds};
      SEL_SDM_RED:   return m_level[0];
      SEL_SDM_GREEN: return m_level[1];
      SEL_SDM_BLUE:  return m_level[2];
      default:       return 16'h0000;  // Unused codes
    endcase
  endfunction

  // Model steps on the same edges as the DUT
  always @(posedge clk) begin
    if (reset_button) begin
      m_out   <= '0;
      m_dir   <= '0;
      m_leds  <= '0;
      m_pulse <= '0;
      m_ack   <= 1'b0;
      for (int i = 0; i < 3; i++) begin
        m_level[i] <= '0;
        m_phase[i] <= '0;
      end
    end else begin
      m_ack <= wb_req.cyc && wb_req.stb && !m_ack;  // One ack, none for a held request
      if (wb_req.cyc && wb_req.stb && !m_ack && wb_req.we) begin
        case (wb_req.adr[5:2])  // Select field
          SEL_PIN_OUT: m_out <= pin_t'(bit_update({8'h00, m_out}, wb_req.dat, wb_req.adr[1:0]));
          SEL_PIN_DIR: m_dir <= pin_t'(bit_update({8'h00, m_dir}, wb_req.dat, wb_req.adr[1:0]));
          SEL_LEDS:
            m_leds <= led_t'(bit_update({13'h0000, m_leds}, wb_req.dat, wb_req.adr[1:0]));
          SEL_SDM_RED:   m_level[0] <= wb_req.dat;  // Op ignored
          SEL_SDM_GREEN: m_level[1] <= wb_req.dat;
          SEL_SDM_BLUE:  m_level[2] <= wb_req.dat;
          default: ;
        endcase
      end
      for (int i = 0; i < 3; i++)
        {m_pulse[i], m_phase[i]} <= {1'b0, m_phase[i]} + {1'b0, m_level[i]};  // Carry out
    end
  end

  task automatic check_val(input string name, input wb_data_t exp, input wb_data_t act);
    n_checks++;
    assert (exp === act)
      else begin
        n_fails++;
        $display("FAILED %s expected %h actual %h at %0t ns", name, exp, act, $time);
      end
  endtask

  // Outputs between edges
  always @(negedge clk) begin
    if (chk_on) begin
      check_val("wb_rsp.dat", 16'h0000, 16'h0000);
      check_val("wb_rsp.ack", {15'h0000, m_ack}, {15'h0000, wb_rsp.ack});
      if (!m_ack || wb_req.we)
        check_val("wb_rsp.dat", 16'h0000, wb_rsp.dat);  // Zero unless a read is acked
      check_val("pin_out", {8'h00, m_out}, {8'h00, pin_out});
      check_val("pin_oe", {8'h00, m_dir}, {8'h00, pin_oe});
      check_val("led_red", {15'h0000, m_leds[0] | m_pulse[0]}, {15'h0000, led_red});
      check_val("led_green", {15'h0000, m_leds[1] | m_pulse[1]}, {15'h0000, led_green});
      check_val("led_blue", {15'h0000, m_leds[2] | m_pulse[2]}, {15'h0000, led_blue});
    end
  end

  // Single-beat access, held until ack
  task automatic bus_access(input logic we, input reg_sel_t sel, input mod_op_t op,
                            input wb_data_t din, output wb_data_t dout);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= we;
    wb_req.adr <= {sel, op};
    wb_req.dat <= din;
    @(negedge clk);
    while (!wb_rsp.ack && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    n_checks++;
    assert (wb_rsp.ack)
      else begin
        n_fails++;
        $display("No ack within 8 cycles for a request to select %0d", sel);
      end
    check_val("ack latency", 16'd1, waited[15:0]);
    dout = wb_rsp.dat;
    @(posedge clk);  // Still held at this edge, must be ignored
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  task automatic bus_write(input reg_sel_t sel, input mod_op_t op, input wb_data_t din);
    wb_data_t unused_rd;
    bus_access(1'b1, sel, op, din, unused_rd);
  endtask

  task automatic read_check(input reg_sel_t sel);
    wb_data_t rd;
    bus_access(1'b0, sel, OP_WRITE, 16'h0000, rd);
    check_val($sformatf("read of select %0d", sel), model_read(sel), rd);
  endtask

  task automatic end_test(input string name, input int fails_at_start);
    $display("test %s finished, %0d failures", name, n_fails - fails_at_start);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int       f0;
    wb_data_t idx;
    wb_data_t rd;
    reg_sel_t sel;
    seed         = 84505;
    n_checks     = 0;
    n_fails      = 0;
    chk_on       = 1'b0;
    reset_button = 1'b1;
    wb_req       = '0;
    pin_in       = '0;
    m_pin        = '0;
    repeat (3) @(posedge clk);
    reset_button <= 1'b0;
    @(posedge clk);
    chk_on = 1'b1;

    // 1: reset state, every select zero
    f0 = n_fails;
    repeat (50) @(posedge clk);
    for (int s = 0; s < 16; s++) begin
      bus_access(1'b0, reg_sel_t'(s), OP_WRITE, 16'h0000, rd);
      check_val($sformatf("reset read of select %0d", s), 16'h0000, rd);
    end
    end_test("reset_state", f0);

    // 2: random modify operations on pins and LEDs
    f0 = n_fails;
    for (int n = 0; n < N_MODIFY; n++) begin
      idx = rand_word() % 16'd3;
      sel = reg_sel_t'(idx) + SEL_PIN_OUT;
      bus_write(sel, mod_op_t'(rand_word()), rand_word());
      read_check(sel);
    end
    end_test("modify_ops", f0);

    // 3: pin input synchronizer
    f0 = n_fails;
    for (int n = 0; n < N_PINS; n++) begin
      @(posedge clk);
      pin_in <= pin_t'(rand_word());
      @(negedge clk);
      m_pin = pin_in;
      repeat (3) @(posedge clk);
      read_check(SEL_PIN_IN);
    end
    end_test("pin_sync", f0);

    // 4: dimmer levels with random LED bits, outputs checked every cycle
    f0 = n_fails;
    for (int n = 0; n < N_DIM; n++) begin
      bus_write(SEL_SDM_RED, mod_op_t'(rand_word()), rand_word());
      bus_write(SEL_SDM_GREEN, mod_op_t'(rand_word()), rand_word());
      bus_write(SEL_SDM_BLUE, mod_op_t'(rand_word()), (n == 0) ? 16'h0000 : rand_word());
      bus_write(SEL_LEDS, OP_WRITE, rand_word());
      repeat (DIM_RUN) @(posedge clk);
      read_check(SEL_SDM_RED);
      read_check(SEL_SDM_GREEN);
      read_check(SEL_SDM_BLUE);
    end
    end_test("dimmer", f0);

    // 5: unused selects and stray strobes
    f0 = n_fails;
    for (int n = 0; n < N_BUS; n++) begin
      idx = rand_word() % 16'd9;
      sel = reg_sel_t'(idx) + 4'd7;
      bus_write(sel, mod_op_t'(rand_word()), rand_word());
      read_check(sel);
      @(posedge clk);
      wb_req.stb <= 1'b1;  // Strobe without cycle
      wb_req.we  <= rand_word() % 16'd2 == 16'd1;
      wb_req.adr <= wb_addr_t'(rand_word());
      wb_req.dat <= rand_word();
      repeat (3) @(posedge clk);
      wb_req.stb <= 1'b0;
      wb_req.cyc <= 1'b1;  // Cycle without strobe
      repeat (2) @(posedge clk);
      wb_req.cyc <= 1'b0;
    end
    for (int s = 1; s < 7; s++)
      read_check(reg_sel_t'(s));  // Nothing changed
    end_test("bus_rules", f0);

    chk_on = 1'b0;
    $display("checks passed %0d, failed %0d", n_checks - n_fails, n_fails);
    if (n_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module wb_reg_slave (
  input  logic             clk,
  input  logic             reset_button,
  input  bus_pkg::wb_req_t wb_req,
  output bus_pkg::wb_rsp_t wb_rsp,
  output bus_pkg::reg_wr_t reg_wr,
  input  io_pkg::gpio_rd_t gpio_rd,
  input  io_pkg::sdm_rd_t  sdm_rd
);

  import bus_pkg::*;

  logic     req;      // Cycle and strobe together
  logic     accept;   // Request not yet acked
  logic     ack_q;
  wb_data_t dat_q;
  wb_data_t rd_word;  // Selected read value, before the register
  reg_sel_t sel;
  mod_op_t  op;

  assign req    = wb_req.cyc & wb_req.stb;
  assign accept = req & ~ack_q;  // Held request in the ack cycle is ignored

  // Address split
  assign sel = wb_req.adr[ADR_SEL_LSB +: REG_SEL_W];
  assign op  = wb_req.adr[ADR_OP_LSB +: MOD_OP_W];

  // Write command, taken by the registers at the ack edge
  assign reg_wr.en   = accept & wb_req.we;
  assign reg_wr.sel  = sel;
  assign reg_wr.op   = op;
  assign reg_wr.data = wb_req.dat;

  // Read mux, narrow fields zero-extended
  always_comb begin
    case (sel)
      SEL_PIN_IN:    rd_word = wb_data_t'(gpio_rd.pin_in);
      SEL_PIN_OUT:   rd_word = wb_data_t'(gpio_rd.pin_out);
      SEL_PIN_DIR:   rd_word = wb_data_t'(gpio_rd.pin_dir);
      SEL_LEDS:      rd_word = wb_data_t'(gpio_rd.leds);
      SEL_SDM_RED:   rd_word = sdm_rd.red;
      SEL_SDM_GREEN: rd_word = sdm_rd.green;
      SEL_SDM_BLUE:  rd_word = sdm_rd.blue;
      default:       rd_word = '0;  // Unused selects read zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_button) begin
      ack_q <= 1'b0;
      dat_q <= '0;
    end else begin
      ack_q <= accept;  // One cycle after the request, never twice in a row
      if (accept && !wb_req.we)
        dat_q <= rd_word;
      else
        dat_q <= '0;    // Bus data idles at zero
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

  // Ack is a single pulse even for a request held past it
  a_ack_single: assert property (@(posedge clk) disable iff (reset_button)
    ack_q |=> !ack_q)
    else $error("wb ack high on two consecutive cycles");

  // No ack without a bus request the cycle before
  a_ack_after_req: assert property (@(posedge clk) disable iff (reset_button)
    ack_q |-> $past(req))
    else $error("wb ack without a preceding request");

endmodule

`default_nettype wire
